// ==== bench/attiny26_programmer_tb.sv ====
`timescale 1ns/1ps

module attiny26_programmer_tb;

	localparam int reset_cycles = 16;

	logic        write, reset, ale, wr, rd;
	logic [7:0]  bus_drive;
	logic        bus_en;
	logic        model_on, model_rdy;
	logic [7:0]  model_byte;
	wire  [7:0]  data;
	wire  [48:1] zif;
	string       lines[$];
	int          cycles = 0, cycle_limit = 0;
	int          errors = 0, test_errors = 0, checks = 0, tests_run = 0;

	assign data = bus_en ? bus_drive : 8'bz;  // Host side of the shared bus

	for (genvar i = 0; i < 8; i++) begin : g_data_pull
		pullup (data[i]);
	end
	for (genvar i = 1; i <= 48; i++) begin : g_zif_pull
		pullup (zif[i]);
	end

	attiny26_programmer i_attiny26_programmer (
		.write (write),
		.reset (reset),
		.ale   (ale),
		.wr    (wr),
		.rd    (rd),
		.data  (data),
		.zif   (zif)
	);

	attiny26_socket_model i_socket_model (
		.zif       (zif),
		.active    (model_on),
		.data_byte (model_byte),
		.rdy_level (model_rdy)
	);

	always #20 write = ~write;

	always @(posedge write) begin
		cycles = cycles + 1;
		if (cycle_limit > 0 && cycles > cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("sim failed");
			$finish;
		end
	end

	task automatic check_value(input logic [7:0] actual, input logic [7:0] expected,
		input string what);
		checks++;
		if (actual !== expected) begin
			$display("MISMATCH at %0t: %s gave %h, expected %h", $time, what, actual, expected);
			errors++;
			test_errors++;
		end
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge write);
	endtask

	task automatic latch_address(input logic [7:0] addr);
		bus_drive = addr;
		bus_en    = 1'b1;
		ale       = 1'b1;
		wait_cycles(6);
		ale = 1'b0;  // Falling ALE takes the address
		wait_cycles(6);
	endtask

	task automatic bus_write(input logic [7:0] addr, input logic [7:0] value);
		latch_address(addr);
		bus_drive = value;
		wr        = 1'b0;
		wait_cycles(6);
		wr = 1'b1;  // Rising WR commits the byte
		wait_cycles(6);
		bus_en = 1'b0;
	endtask

	task automatic bus_read(input logic [7:0] addr, input logic [7:0] expected);
		latch_address(addr);
		bus_en = 1'b0;
		rd     = 1'b0;
		wait_cycles(6);
		check_value(data, expected, $sformatf("read of address %h", addr));
		rd = 1'b1;
		wait_cycles(6);
	endtask

	task automatic expect_pin(input int pin, input logic level);
		check_value({7'b0, zif[pin]}, {7'b0, level}, $sformatf("ZIF pin %0d", pin));
	endtask

	task automatic close_test(input int test_no);
		if (test_no >= 0) begin
			if (test_errors == 0)
				$display("Test %0d done, no errors", test_no);
			else
				$display("Test %0d done, %0d errors", test_no, test_errors);
			tests_run++;
		end
		test_errors = 0;
	endtask

	initial begin : main_seq
		int         fd, n, test_no, current, file_lines;
		logic [7:0] a, b;
		byte        op;
		string      line;
		write      = 1'b0;
		reset      = 1'b1;
		ale        = 1'b0;
		wr         = 1'b1;
		rd         = 1'b1;
		bus_drive  = 8'h00;
		bus_en     = 1'b0;
		model_on   = 1'b0;
		model_rdy  = 1'b0;
		model_byte = 8'h00;
		file_lines = 0;
		current = -1;
		fd = $fopen("bench/programmer_input.txt", "r");
		if (fd == 0) begin
			$display("Could not open bench/programmer_input.txt for reading");
			errors++;
		end else begin
			while ($fgets(line, fd) > 0) begin
				file_lines++;
				if (line.len() > 1 && line[0] != "#")
					lines.push_back(line);
			end
			$fclose(fd);
		end
		cycle_limit = 40 * file_lines + reset_cycles + 200;
		wait_cycles(reset_cycles);
		reset = 1'b0;
		wait_cycles(2);
		foreach (lines[i]) begin
			line = lines[i];
			if (line[0] == "P")
				n = $sscanf(line, "%c %d %d %d", op, test_no, a, b);
			else
				n = $sscanf(line, "%c %d %h %h", op, test_no, a, b);
			if (n != 4) begin
				$display("Could not parse stimulus line: %s", line);
				errors++;
			end else begin
				if (test_no != current) begin
					close_test(current);
					current = test_no;
				end
				case (op)
					"W": bus_write(a, b);
					"R": bus_read(a, b);
					"P": expect_pin(a, b[0]);
					"M": begin
						model_byte = a;  // Chip answer for later reads
						model_rdy  = b[0];
						model_on   = 1'b1;
					end
					default: begin
						$display("Unknown operation in stimulus line: %s", line);
						errors++;
					end
				endcase
			end
		end
		close_test(current);
		$display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// ==== bench/attiny26_socket_model.sv ====
`timescale 1ns/1ps

module attiny26_socket_model (
	inout  wire  [48:1] zif,
	input  logic        active,
	input  logic [7:0]  data_byte,
	input  logic        rdy_level
);

	logic drive_data;

	// The chip answers only while OE is low, and only once it holds a byte
	assign drive_data = active & (zif[zif_pkg::pin_oe] === 1'b0);

	assign zif[zif_pkg::pin_data0] = drive_data ? data_byte[0] : 1'bz;
	assign zif[zif_pkg::pin_data1] = drive_data ? data_byte[1] : 1'bz;
	assign zif[zif_pkg::pin_data2] = drive_data ? data_byte[2] : 1'bz;
	assign zif[zif_pkg::pin_data3] = drive_data ? data_byte[3] : 1'bz;
	assign zif[zif_pkg::pin_data4] = drive_data ? data_byte[4] : 1'bz;
	assign zif[zif_pkg::pin_data5] = drive_data ? data_byte[5] : 1'bz;
	assign zif[zif_pkg::pin_data6] = drive_data ? data_byte[6] : 1'bz;
	assign zif[zif_pkg::pin_data7] = drive_data ? data_byte[7] : 1'bz;
	assign zif[zif_pkg::pin_rdy]   = active ? rdy_level : 1'bz;  // RDY/BSY

endmodule

// ==== bench/programmer_input.txt ====
# op test a b with a and b in hex: W addr byte, R addr expected, M model_byte rdy
# P test pin level with pin number and level in decimal
P 1 21 1
P 1 16 1
P 1 32 1
P 1 37 1
P 1 31 0
P 1 17 0
P 1 33 0
W 2 10 A5
W 2 12 82
P 2 21 1
P 2 20 0
P 2 19 1
P 2 18 0
P 2 15 0
P 2 14 1
P 2 13 0
P 2 12 1
W 3 11 0D
P 3 16 1
P 3 37 0
W 3 11 05
P 3 32 0
P 3 37 0
W 3 11 00
P 3 32 1
P 3 37 1
W 4 12 83
P 4 28 1
W 4 12 89
P 4 31 1
W 4 12 8A
P 4 30 1
W 4 12 85
P 4 29 1
W 4 12 87
P 4 34 1
W 4 12 01
W 4 12 08
P 4 28 1
W 4 12 04
P 4 31 0
W 5 12 02
M 5 3C 1
R 5 10 3C
R 5 12 01
M 5 C3 0
R 5 10 C3
R 5 12 00
R 6 FD 26
R 6 FE 00
R 6 FF 01
R 6 01 FF

// ==== sim.f ====
verilog/zif_pkg.sv
verilog/host_bus_port.sv
verilog/prog_registers.sv
verilog/readback_mux.sv
verilog/zif_pin_driver.sv
verilog/attiny26_programmer.sv
bench/attiny26_socket_model.sv
bench/attiny26_programmer_tb.sv

// ==== verilog/attiny26_programmer.sv ====
`timescale 1ns/1ps

module attiny26_programmer (
	input  logic        write,
	input  logic        reset,
	input  logic        ale,
	input  logic        wr,
	input  logic        rd,
	inout  wire  [7:0]  data,
	inout  wire  [48:1] zif
);

	logic [7:0] address;
	logic [7:0] wdata;
	logic [7:0] rdata;
	logic       reg_write;
	logic       reg_read;
	logic [7:0] dut_data;
	logic       dut_oe, dut_wr, dut_xtal;
	logic       dut_pagel_bs1, dut_xa0, dut_xa1_bs2;
	logic       vcc, vcc_en, vpp, vpp_en;
	logic [7:0] pin_byte;
	logic       rdy;

	host_bus_port i_host_bus_port (
		.write     (write),
		.reset     (reset),
		.ale       (ale),
		.wr        (wr),
		.rd        (rd),
		.data      (data),
		.rdata     (rdata),
		.address   (address),
		.wdata     (wdata),
		.reg_write (reg_write),
		.reg_read  (reg_read)
	);

	prog_registers i_prog_registers (
		.write         (write),
		.reset         (reset),
		.reg_write     (reg_write),
		.address       (address),
		.wdata         (wdata),
		.dut_data      (dut_data),
		.dut_oe        (dut_oe),
		.dut_wr        (dut_wr),
		.dut_xtal      (dut_xtal),
		.dut_pagel_bs1 (dut_pagel_bs1),
		.dut_xa0       (dut_xa0),
		.dut_xa1_bs2   (dut_xa1_bs2),
		.vcc           (vcc),
		.vcc_en        (vcc_en),
		.vpp           (vpp),
		.vpp_en        (vpp_en)
	);

	readback_mux i_readback_mux (
		.write    (write),
		.reset    (reset),
		.reg_read (reg_read),
		.address  (address),
		.pin_byte (pin_byte),
		.rdy      (rdy),
		.rdata    (rdata)
	);

	zif_pin_driver i_zif_pin_driver (
		.write         (write),
		.reset         (reset),
		.dut_data      (dut_data),
		.dut_oe        (dut_oe),
		.dut_wr        (dut_wr),
		.dut_xtal      (dut_xtal),
		.dut_pagel_bs1 (dut_pagel_bs1),
		.dut_xa0       (dut_xa0),
		.dut_xa1_bs2   (dut_xa1_bs2),
		.vcc           (vcc),
		.vcc_en        (vcc_en),
		.vpp           (vpp),
		.vpp_en        (vpp_en),
		.zif           (zif),
		.pin_byte      (pin_byte),
		.rdy           (rdy)
	);

endmodule

// ==== verilog/host_bus_port.sv ====
`timescale 1ns/1ps

module host_bus_port (
	input  logic       write,
	input  logic       reset,
	input  logic       ale,
	input  logic       wr,
	input  logic       rd,
	inout  wire  [7:0] data,
	input  logic [7:0] rdata,
	output logic [7:0] address,
	output logic [7:0] wdata,
	output logic       reg_write,
	output logic       reg_read
);

	logic       ale_s1, ale_s2, ale_q;
	logic       wr_s1, wr_s2, wr_q;
	logic       rd_s1, rd_s2, rd_q;
	logic [7:0] data_s1, data_s2;
	logic       ale_fall;
	logic       wr_rise;
	logic       rd_fall;
	logic       bus_oe;

	// Two-stage synchronizers plus one stage for edge detection
	always_ff @(posedge write) begin
		ale_s1  <= ale;
		ale_s2  <= ale_s1;
		ale_q   <= ale_s2;
		wr_s1   <= wr;
		wr_s2   <= wr_s1;
		wr_q    <= wr_s2;
		rd_s1   <= rd;
		rd_s2   <= rd_s1;
		rd_q    <= rd_s2;
		data_s1 <= data;
		data_s2 <= data_s1;
	end

	assign ale_fall = ale_q & ~ale_s2;
	assign wr_rise  = wr_s2 & ~wr_q;
	assign rd_fall  = rd_q & ~rd_s2;

	// Register events land on the third clock after the strobe edge
	always_ff @(posedge write) begin
		if (reset) begin
			address   <= 8'h00;
			reg_write <= 1'b0;
			reg_read  <= 1'b0;
		end else begin
			reg_write <= wr_rise;
			reg_read  <= rd_fall;
			if (ale_fall)
				address <= data_s2;  // Multiplexed bus carries the address here
		end
	end

	// Byte on the bus when WR rises
	always_ff @(posedge write) begin
		if (wr_rise)
			wdata <= data_s2;
	end

	// rd_q turns the driver on one clock before the new rdata arrives
	assign bus_oe = ~rd_q & address[4];
	assign data   = bus_oe ? rdata : 8'bz;

endmodule

// ==== verilog/prog_registers.sv ====
`timescale 1ns/1ps

module prog_registers (
	input  logic       write,
	input  logic       reset,
	input  logic       reg_write,
	input  logic [7:0] address,
	input  logic [7:0] wdata,
	output logic [7:0] dut_data,
	output logic       dut_oe,
	output logic       dut_wr,
	output logic       dut_xtal,
	output logic       dut_pagel_bs1,
	output logic       dut_xa0,
	output logic       dut_xa1_bs2,
	output logic       vcc,
	output logic       vcc_en,
	output logic       vpp,
	output logic       vpp_en
);

	zif_pkg::host_word cmd;

	assign cmd = wdata;

	always_ff @(posedge write) begin
		if (reset) begin
			dut_data      <= 8'h00;
			dut_oe        <= 1'b0;
			dut_wr        <= 1'b0;
			dut_xtal      <= 1'b0;
			dut_pagel_bs1 <= 1'b0;
			dut_xa0       <= 1'b0;
			dut_xa1_bs2   <= 1'b0;
			vcc           <= 1'b0;
			vcc_en        <= 1'b0;
			vpp           <= 1'b0;
			vpp_en        <= 1'b0;
		end else if (reg_write) begin
			case (address)
				zif_pkg::reg_data: dut_data <= wdata;
				zif_pkg::reg_supply: begin
					vcc    <= cmd.supply_cmd.vcc;
					vcc_en <= cmd.supply_cmd.vcc_en;
					vpp    <= cmd.supply_cmd.vpp;
					vpp_en <= cmd.supply_cmd.vpp_en;
				end
				zif_pkg::reg_control: begin
					// One pin per write, level from bit 7
					case (cmd.ctrl_cmd.sel)
						zif_pkg::sel_oe:   dut_oe   <= cmd.ctrl_cmd.level;
						zif_pkg::sel_wr:   dut_wr   <= cmd.ctrl_cmd.level;
						zif_pkg::sel_xa0:  dut_xa0  <= cmd.ctrl_cmd.level;
						zif_pkg::sel_xtal: dut_xtal <= cmd.ctrl_cmd.level;
						zif_pkg::sel_pagel_bs1,
						zif_pkg::sel_pagel_bs1_alt:
							dut_pagel_bs1 <= cmd.ctrl_cmd.level;
						zif_pkg::sel_xa1_bs2,
						zif_pkg::sel_xa1_bs2_alt:
							dut_xa1_bs2 <= cmd.ctrl_cmd.level;
						default: ;  // Selectors 1 and 8 are no-ops
					endcase
				end
				default: ;  // Read-only or unmapped address
			endcase
		end
	end

endmodule

// ==== verilog/readback_mux.sv ====
`timescale 1ns/1ps

module readback_mux (
	input  logic       write,
	input  logic       reset,
	input  logic       reg_read,
	input  logic [7:0] address,
	input  logic [7:0] pin_byte,
	input  logic       rdy,
	output logic [7:0] rdata
);

	logic [7:0] status;

	assign status = {7'b0000000, rdy};  // RDY/BSY in bit 0

	// pin_byte and rdy are already synchronized in the pin driver
	always_ff @(posedge write) begin
		if (reset) begin
			rdata <= 8'h00;
		end else if (reg_read) begin
			case (address)
				zif_pkg::reg_data:    rdata <= pin_byte;
				zif_pkg::reg_control: rdata <= status;
				zif_pkg::reg_id_lo:   rdata <= zif_pkg::runtime_id[7:0];
				zif_pkg::reg_id_hi:   rdata <= zif_pkg::runtime_id[15:8];
				zif_pkg::reg_rev:     rdata <= zif_pkg::runtime_rev;
				default: ;  // Keep the last byte
			endcase
		end
	end

endmodule

// ==== verilog/zif_pin_driver.sv ====
`timescale 1ns/1ps

module zif_pin_driver (
	input  logic        write,
	input  logic        reset,
	input  logic [7:0]  dut_data,
	input  logic        dut_oe,
	input  logic        dut_wr,
	input  logic        dut_xtal,
	input  logic        dut_pagel_bs1,
	input  logic        dut_xa0,
	input  logic        dut_xa1_bs2,
	input  logic        vcc,
	input  logic        vcc_en,
	input  logic        vpp,
	input  logic        vpp_en,
	inout  wire  [48:1] zif,
	output logic [7:0]  pin_byte,
	output logic        rdy
);

	logic [48:1] pin_out;
	logic [48:1] pin_en;
	logic [7:0]  byte_s1;
	logic        rdy_s1;

	always_comb begin
		pin_out = '0;  // Unused pins are held low
		pin_en  = '1;
		// Data pins, driven only while OE is high
		pin_out[zif_pkg::pin_data0] = dut_data[0];
		pin_out[zif_pkg::pin_data1] = dut_data[1];
		pin_out[zif_pkg::pin_data2] = dut_data[2];
		pin_out[zif_pkg::pin_data3] = dut_data[3];
		pin_out[zif_pkg::pin_data4] = dut_data[4];
		pin_out[zif_pkg::pin_data5] = dut_data[5];
		pin_out[zif_pkg::pin_data6] = dut_data[6];
		pin_out[zif_pkg::pin_data7] = dut_data[7];
		pin_en[zif_pkg::pin_data0]  = dut_oe;
		pin_en[zif_pkg::pin_data1]  = dut_oe;
		pin_en[zif_pkg::pin_data2]  = dut_oe;
		pin_en[zif_pkg::pin_data3]  = dut_oe;
		pin_en[zif_pkg::pin_data4]  = dut_oe;
		pin_en[zif_pkg::pin_data5]  = dut_oe;
		pin_en[zif_pkg::pin_data6]  = dut_oe;
		pin_en[zif_pkg::pin_data7]  = dut_oe;
		pin_out[zif_pkg::pin_avcc]      = vcc;
		pin_en[zif_pkg::pin_avcc]       = vcc_en;
		pin_out[zif_pkg::pin_vcc]       = vcc;
		pin_en[zif_pkg::pin_vcc]        = vcc_en;
		pin_out[zif_pkg::pin_reset_vpp] = vpp;
		pin_en[zif_pkg::pin_reset_vpp]  = vpp_en;
		pin_out[zif_pkg::pin_gnd_a]     = 1'b0;
		pin_out[zif_pkg::pin_gnd_b]     = 1'b0;
		pin_out[zif_pkg::pin_wr]        = dut_wr;
		pin_out[zif_pkg::pin_xa0]       = dut_xa0;
		pin_out[zif_pkg::pin_xa1_bs2]   = dut_xa1_bs2;
		pin_out[zif_pkg::pin_pagel_bs1] = dut_pagel_bs1;
		pin_out[zif_pkg::pin_xtal]      = dut_xtal;
		pin_out[zif_pkg::pin_oe]        = dut_oe;
		pin_en[zif_pkg::pin_rdy]        = 1'b0;  // Chip drives RDY/BSY
	end

	for (genvar i = 1; i <= 48; i++) begin : g_pin
		assign zif[i] = pin_en[i] ? pin_out[i] : 1'bz;
	end

	// Socket inputs are asynchronous to the clock
	always_ff @(posedge write) begin
		if (reset) begin
			byte_s1  <= 8'h00;
			pin_byte <= 8'h00;
			rdy_s1   <= 1'b0;
			rdy      <= 1'b0;
		end else begin
			byte_s1  <= {zif[zif_pkg::pin_data7], zif[zif_pkg::pin_data6],
				zif[zif_pkg::pin_data5], zif[zif_pkg::pin_data4],
				zif[zif_pkg::pin_data3], zif[zif_pkg::pin_data2],
				zif[zif_pkg::pin_data1], zif[zif_pkg::pin_data0]};
			pin_byte <= byte_s1;
			rdy_s1   <= zif[zif_pkg::pin_rdy];
			rdy      <= rdy_s1;
		end
	end

endmodule

// ==== verilog/zif_pkg.sv ====
package zif_pkg;

	// Host register map
	localparam logic [7:0] reg_data    = 8'h10;  // Data byte, write and read-back
	localparam logic [7:0] reg_supply  = 8'h11;  // VCC/VPP control, write only
	localparam logic [7:0] reg_control = 8'h12;  // Control pin write, status read
	localparam logic [7:0] reg_id_lo   = 8'hFD;
	localparam logic [7:0] reg_id_hi   = 8'hFE;
	localparam logic [7:0] reg_rev     = 8'hFF;

	// Design identification
	localparam logic [15:0] runtime_id  = 16'h0026;
	localparam logic [7:0]  runtime_rev = 8'h01;

	// Control pin selectors, carried in the low 7 bits of a control write
	localparam logic [6:0] sel_oe            = 7'd2;
	localparam logic [6:0] sel_wr            = 7'd3;
	localparam logic [6:0] sel_pagel_bs1     = 7'd4;
	localparam logic [6:0] sel_xa0           = 7'd5;
	localparam logic [6:0] sel_xa1_bs2       = 7'd6;
	localparam logic [6:0] sel_xtal          = 7'd7;
	localparam logic [6:0] sel_pagel_bs1_alt = 7'd9;
	localparam logic [6:0] sel_xa1_bs2_alt   = 7'd10;

	// ZIF socket pin numbers for a 20-pin DIP
	localparam int pin_data0     = 21;  // PA0
	localparam int pin_data1     = 20;  // PA1
	localparam int pin_data2     = 19;  // PA2
	localparam int pin_data3     = 18;  // PA3
	localparam int pin_data4     = 15;  // PA4
	localparam int pin_data5     = 14;  // PA5
	localparam int pin_data6     = 13;  // PA6
	localparam int pin_data7     = 12;  // PA7
	localparam int pin_avcc      = 16;
	localparam int pin_gnd_a     = 17;
	localparam int pin_wr        = 28;  // PB0, active low
	localparam int pin_xa0       = 29;  // PB1
	localparam int pin_xa1_bs2   = 30;  // PB2
	localparam int pin_pagel_bs1 = 31;  // PB3
	localparam int pin_vcc       = 32;
	localparam int pin_gnd_b     = 33;
	localparam int pin_xtal      = 34;  // PB4, XTAL1
	localparam int pin_oe        = 35;  // PB5, active low
	localparam int pin_rdy       = 36;  // PB6, RDY/BSY from the chip
	localparam int pin_reset_vpp = 37;  // PB7, reset and high voltage

	// One host byte, read as a control command or a supply command
	typedef union packed {
		struct packed {
			logic       level;  // New level of the selected pin
			logic [6:0] sel;
		} ctrl_cmd;
		struct packed {
			logic [3:0] reserved;
			logic       vcc;
			logic       vcc_en;
			logic       vpp;
			logic       vpp_en;
		} supply_cmd;
	} host_word;

endpackage
